// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // base opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam word_t INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [2:0] {
        PH_FETCH      = 3'd0,
        PH_DECODE     = 3'd1,
        PH_REG_READ   = 3'd2,
        PH_EXEC       = 3'd3,
        PH_MEM        = 3'd4,
        PH_WRITE_BACK = 3'd5,
        PH_PC_NEXT    = 3'd6,
        PH_HALT       = 3'd7
    } phase_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic       alt;
        word_t      imm;
    } dec_t;

    // result is either an ALU value or an effective address
    typedef struct packed {
        word_t result;
        addr_t next_pc;
        logic  branch_taken;
    } exec_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  word_t instr,
    output dec_t  dec
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;

    // ============================================================
    // immediate formats
    // ============================================================

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // ============================================================
    // field split
    // ============================================================

    always_comb begin
        dec.opcode = opcode_e'(instr[6:0]);
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        // funct7 bit 5 selects sub
        dec.alt    = instr[30];

        case (dec.opcode)
            OPC_STORE:  dec.imm = imm_s;
            OPC_BRANCH: dec.imm = imm_b;
            OPC_LUI:    dec.imm = imm_u;
            default:    dec.imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     sys_clk,
    input  logic     sys_rst,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  logic     rd_we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 and unimplemented indices read as zero
    assign rs1_val = (rs1_idx == '0 || rs1_idx >= NUM_REGS) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0 || rs2_idx >= NUM_REGS) ? '0 : regs[rs2_idx];

    a_rd_in_range: assert property (
        @(posedge sys_clk) disable iff (sys_rst) rd_we |-> (rd < NUM_REGS)
    ) else $error("register write to index %0d beyond file size", rd);

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  dec_t  dec,
    input  word_t op_a,
    input  word_t op_b,
    input  addr_t pc,
    output exec_t exec
);

    logic operands_eq;
    logic take;

    assign operands_eq = (op_a == op_b);

    always_comb begin
        case (dec.opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_STORE: begin
                exec.result = op_a + dec.imm;
            end
            OPC_OP: begin
                exec.result = dec.alt ? (op_a - op_b) : (op_a + op_b);
            end
            OPC_LUI: begin
                exec.result = dec.imm;
            end
            default: begin
                exec.result = '0;
            end
        endcase
    end

    // beq / bne only
    always_comb begin
        take = 1'b0;
        if (dec.opcode == OPC_BRANCH) begin
            case (dec.funct3)
                3'b000:  take = operands_eq;
                3'b001:  take = !operands_eq;
                default: take = 1'b0;
            endcase
        end
    end

    assign exec.branch_taken = take;
    assign exec.next_pc      = take ? (pc + dec.imm) : (pc + addr_t'(4));

endmodule

`default_nettype wire

// File: logic/rv_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module rv_apb_master import rv_pkg::*; (
    input  logic     sys_clk,
    input  logic     sys_rst,
    input  logic     mem_start,
    input  mem_req_t mem_req,
    output logic     mem_done,
    output word_t    mem_rdata,
    output logic     psel,
    output logic     penable,
    output logic     pwrite,
    output addr_t    paddr,
    output word_t    pwdata,
    input  logic     pready,
    input  word_t    prdata
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    apb_state_e state;
    mem_req_t   req_q;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state    <= APB_IDLE;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                APB_IDLE: begin
                    if (mem_start) begin
                        state <= APB_SETUP;
                    end
                end
                APB_SETUP: state <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready) begin
                        state    <= APB_IDLE;
                        mem_done <= 1'b1;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == APB_IDLE && mem_start) begin
            req_q <= mem_req;
        end
        if (state == APB_ACCESS && pready) begin
            mem_rdata <= prdata;
        end
    end

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);
    assign pwrite  = psel && req_q.write;
    assign paddr   = req_q.addr;
    assign pwdata  = req_q.wdata;

    // address and data held until the access completes
    a_apb_stable: assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        psel && !(penable && pready) |=>
            $stable(paddr) && $stable(pwrite) && $stable(pwdata)
    ) else $error("apb request changed before completion");

endmodule

`default_nettype wire

// File: logic/rv_ctl_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctl_unit import rv_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic     sys_clk,
    input  logic     sys_rst,
    output logic     mem_start,
    output mem_req_t mem_req,
    input  logic     mem_done,
    input  word_t    mem_rdata,
    output word_t    instr,
    input  dec_t     dec,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output word_t    op_a,
    output word_t    op_b,
    output addr_t    pc,
    input  exec_t    exec,
    output logic     rd_we,
    output reg_idx_t rd,
    output word_t    rd_data,
    output logic     halted
);

    phase_e phase;
    logic   mem_busy;
    exec_t  exec_q;
    word_t  load_q;
    logic   is_load;
    logic   is_store;
    logic   writes_rd;

    assign is_load   = (dec.opcode == OPC_LOAD);
    assign is_store  = (dec.opcode == OPC_STORE);
    assign writes_rd = is_load || dec.opcode inside {OPC_OP_IMM, OPC_OP, OPC_LUI};

    // ============================================================
    // phase sequencing
    // ============================================================

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            phase     <= PH_FETCH;
            pc        <= RESET_PC;
            mem_start <= 1'b0;
            mem_busy  <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            case (phase)
                PH_FETCH: begin
                    if (!mem_busy) begin
                        mem_start <= 1'b1;
                        mem_busy  <= 1'b1;
                    end else if (mem_done) begin
                        mem_busy <= 1'b0;
                        phase    <= PH_DECODE;
                    end
                end
                PH_DECODE: begin
                    phase <= (instr == INSTR_EBREAK) ? PH_HALT : PH_REG_READ;
                end
                PH_REG_READ: phase <= PH_EXEC;
                PH_EXEC:     phase <= PH_MEM;
                PH_MEM: begin
                    if (!(is_load || is_store)) begin
                        phase <= PH_WRITE_BACK;
                    end else if (!mem_busy) begin
                        mem_start <= 1'b1;
                        mem_busy  <= 1'b1;
                    end else if (mem_done) begin
                        mem_busy <= 1'b0;
                        phase    <= PH_WRITE_BACK;
                    end
                end
                PH_WRITE_BACK: phase <= PH_PC_NEXT;
                PH_PC_NEXT: begin
                    pc    <= exec_q.next_pc;
                    phase <= PH_FETCH;
                end
                default: phase <= PH_HALT;
            endcase
        end
    end

    // ============================================================
    // datapath registers
    // ============================================================

    always_ff @(posedge sys_clk) begin
        if (phase == PH_FETCH && !mem_busy) begin
            mem_req <= '{write: 1'b0, addr: pc, wdata: '0};
        end
        if (phase == PH_FETCH && mem_done) begin
            instr <= mem_rdata;
        end
        if (phase == PH_REG_READ) begin
            op_a <= rs1_val;
            op_b <= rs2_val;
        end
        if (phase == PH_EXEC) begin
            exec_q <= exec;
        end
        // store data comes from rs2
        if (phase == PH_MEM && !mem_busy) begin
            mem_req <= '{write: is_store, addr: exec_q.result, wdata: op_b};
        end
        if (phase == PH_MEM && mem_done) begin
            load_q <= mem_rdata;
        end
    end

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    assign rd_we   = (phase == PH_WRITE_BACK) && writes_rd;
    assign rd      = dec.rd;
    assign rd_data = is_load ? load_q : exec_q.result;

    assign halted  = (phase == PH_HALT);

    // all eight codes are phases, so only an unknown value is illegal
    a_phase_legal: assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        !$isunknown(phase)
    ) else $error("phase register holds an illegal value");

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; #(
    parameter addr_t RESET_PC = '0,
    parameter int    NUM_REGS = 32
) (
    input  logic  sys_clk,
    input  logic  sys_rst,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    output addr_t paddr,
    output word_t pwdata,
    input  logic  pready,
    input  word_t prdata,
    output logic  halted
);

    logic     mem_start;
    logic     mem_done;
    mem_req_t mem_req;
    word_t    mem_rdata;
    word_t    instr;
    dec_t     dec;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    op_a;
    word_t    op_b;
    addr_t    pc;
    exec_t    exec;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;

    rv_ctl_unit #(
        .RESET_PC(RESET_PC)
    ) u_ctl_unit (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .mem_start(mem_start),
        .mem_req  (mem_req),
        .mem_done (mem_done),
        .mem_rdata(mem_rdata),
        .instr    (instr),
        .dec      (dec),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .op_a     (op_a),
        .op_b     (op_b),
        .pc       (pc),
        .exec     (exec),
        .rd_we    (rd_we),
        .rd       (rd),
        .rd_data  (rd_data),
        .halted   (halted)
    );

    rv_decoder u_decoder (
        .instr(instr),
        .dec  (dec)
    );

    rv_reg_file #(
        .NUM_REGS(NUM_REGS)
    ) u_reg_file (
        .sys_clk(sys_clk),
        .sys_rst(sys_rst),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .rd_we  (rd_we),
        .rd     (rd),
        .rd_data(rd_data)
    );

    rv_execute u_execute (
        .dec (dec),
        .op_a(op_a),
        .op_b(op_b),
        .pc  (pc),
        .exec(exec)
    );

    // fetch and data accesses share this port
    rv_apb_master u_apb_master (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .mem_start(mem_start),
        .mem_req  (mem_req),
        .mem_done (mem_done),
        .mem_rdata(mem_rdata),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pready   (pready),
        .prdata   (prdata)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rst
);

    initial begin
        sys_clk = 1'b0;
    end

    always #5 sys_clk = ~sys_clk;

    // reset held for four rising edges
    initial begin
        sys_rst = 1'b1;
        repeat (4) @(posedge sys_clk);
        sys_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_apb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_mem import rv_pkg::*; #(
    parameter int MEM_WORDS = 128,
    parameter int MAX_WAIT  = 3
) (
    input  logic  sys_clk,
    input  logic  sys_rst,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  word_t pwdata,
    output logic  pready,
    output word_t prdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t  mem [MEM_WORDS];
    integer seed;
    int     wait_left;
    int     pick;

    initial begin
        seed      = 32'hbd2c;
        pready    = 1'b0;
        prdata    = '0;
        wait_left = 0;
    end

    always @(posedge sys_clk) begin
        if (sys_rst) begin
            pready    <= 1'b0;
            wait_left <= 0;
        end else if (psel && !penable) begin
            // setup cycle, draw the number of wait states
            pick = $unsigned($random(seed)) % (MAX_WAIT + 1);
            wait_left <= pick;
            pready    <= (pick == 0);
            prdata    <= mem[paddr[IDX_W+1:2]];
        end else if (psel && penable && !pready) begin
            wait_left <= wait_left - 1;
            pready    <= (wait_left == 1);
            prdata    <= mem[paddr[IDX_W+1:2]];
        end else if (psel && penable && pready) begin
            if (pwrite) begin
                mem[paddr[IDX_W+1:2]] <= pwdata;
            end
            pready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam addr_t RESET_PC      = '0;
    localparam int    MEM_WORDS     = 128;
    localparam int    MAX_WAIT      = 3;
    localparam int    IDX_W         = $clog2(MEM_WORDS);
    localparam int    MAX_STEPS     = 1000;
    localparam int    RESET_TIMEOUT = 20;
    localparam int    HALT_TIMEOUT  = 20000;

    logic  sys_clk;
    logic  sys_rst;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    logic  pready;
    word_t prdata;
    logic  halted;

    word_t image [MEM_WORDS];
    int    prog_len;
    addr_t exp_addr_q [$];
    word_t exp_data_q [$];
    int    exp_count;
    int    store_count;
    logic  first_seen;
    addr_t hold_addr;
    word_t hold_data;
    logic  hold_write;

    tb_clk_gen u_clk (
        .sys_clk(sys_clk),
        .sys_rst(sys_rst)
    );

    tb_apb_mem #(
        .MEM_WORDS(MEM_WORDS),
        .MAX_WAIT (MAX_WAIT)
    ) u_mem (
        .sys_clk(sys_clk),
        .sys_rst(sys_rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .pready (pready),
        .prdata (prdata)
    );

    rv_core_top #(
        .RESET_PC(RESET_PC),
        .NUM_REGS(32)
    ) dut (
        .sys_clk(sys_clk),
        .sys_rst(sys_rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .pready (pready),
        .prdata (prdata),
        .halted (halted)
    );

    // ============================================================
    // failure reporting and checks
    // ============================================================

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_problem(input string reason);
        $display("ERROR: %s", reason);
        abort_run();
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ============================================================
    // instruction encoding and program
    // ============================================================

    function automatic word_t i_type(opcode_e opc, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t r_type(logic alt, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic word_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic place(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = 32'hc0de_0000 | (i * 4);
        end
        prog_len = 0;
        place(i_type(OPC_OP_IMM, 3'b000, 10, 0, 12'h100));
        place(u_type(2, 20'h12345));
        place(i_type(OPC_OP_IMM, 3'b000, 2, 2, 12'h678));
        place(s_type(2, 10, 0));
        place(i_type(OPC_OP_IMM, 3'b000, 3, 0, -5));
        place(r_type(1'b0, 4, 2, 3));
        place(s_type(4, 10, 4));
        place(r_type(1'b1, 5, 0, 3));
        place(s_type(5, 10, 8));
        // writes to x0 must vanish
        place(i_type(OPC_OP_IMM, 3'b000, 0, 0, 123));
        place(r_type(1'b0, 0, 2, 2));
        place(s_type(0, 10, 12));
        place(i_type(OPC_LOAD, 3'b010, 6, 10, 0));
        place(i_type(OPC_OP_IMM, 3'b000, 6, 6, 1));
        place(s_type(6, 10, 16));
        // countdown loop with a backward bne
        place(i_type(OPC_OP_IMM, 3'b000, 7, 0, 3));
        place(i_type(OPC_OP_IMM, 3'b000, 8, 0, 0));
        place(r_type(1'b0, 8, 8, 7));
        place(s_type(8, 10, 20));
        place(i_type(OPC_OP_IMM, 3'b000, 7, 7, -1));
        place(b_type(3'b001, 7, 0, -12));
        place(b_type(3'b000, 7, 0, 8));
        place(s_type(2, 10, 24));
        place(b_type(3'b000, 8, 0, 8));
        place(s_type(8, 10, 28));
        place(b_type(3'b001, 8, 8, 8));
        place(i_type(OPC_LOAD, 3'b010, 9, 10, 20));
        place(r_type(1'b1, 9, 9, 5));
        place(s_type(9, 10, 32));
        // fence, retires as a no-op
        place(32'h0000_000f);
        place(32'h0010_0073);
    endtask

    // ============================================================
    // reference model
    // ============================================================

    function automatic int run_reference();
        word_t    regs [32];
        word_t    ref_mem [MEM_WORDS];
        addr_t    pc;
        addr_t    next_pc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        word_t    ea;
        word_t    val;
        logic     wr;
        reg_idx_t rd_i;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = image[i];
        end
        pc = RESET_PC;
        for (int step = 0; step < MAX_STEPS; step++) begin
            ins = ref_mem[pc[IDX_W+1:2]];
            if (ins == 32'h0010_0073) begin
                return step;
            end
            rd_i    = ins[11:7];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            next_pc = pc + 4;
            wr      = 1'b0;
            val     = '0;
            case (ins[6:0])
                OPC_OP_IMM: begin
                    wr  = 1'b1;
                    val = a + imm_i;
                end
                OPC_OP: begin
                    wr  = 1'b1;
                    val = ins[30] ? a - b : a + b;
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    val = {ins[31:12], 12'b0};
                end
                OPC_LOAD: begin
                    ea  = a + imm_i;
                    wr  = 1'b1;
                    val = ref_mem[ea[IDX_W+1:2]];
                end
                OPC_STORE: begin
                    ea = a + imm_s;
                    ref_mem[ea[IDX_W+1:2]] = b;
                    exp_addr_q.push_back(ea);
                    exp_data_q.push_back(b);
                end
                OPC_BRANCH: begin
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: begin
                end
            endcase
            if (wr && rd_i != 0) begin
                regs[rd_i] = val;
            end
            pc = next_pc;
        end
        return -1;
    endfunction

    // ============================================================
    // bus monitor and store comparison
    // ============================================================

    always @(posedge sys_clk) begin
        if (!sys_rst) begin
            if (!first_seen && psel) begin
                check_addr("first fetch address", RESET_PC, paddr);
                check_flag("first transfer is a read", 1'b0, pwrite);
                first_seen = 1'b1;
            end
            if (psel && !penable) begin
                hold_addr  = paddr;
                hold_data  = pwdata;
                hold_write = pwrite;
            end
            if (psel && penable) begin
                check_addr("paddr held during access", hold_addr, paddr);
                check_word("pwdata held during access", hold_data, pwdata);
                check_flag("pwrite held during access", hold_write, pwrite);
            end
            if (psel && penable && pready && pwrite) begin
                if (exp_addr_q.size() == 0) begin
                    report_problem("the core stored more words than the reference predicts");
                end else begin
                    check_addr($sformatf("store %0d address", store_count),
                               exp_addr_q.pop_front(), paddr);
                    check_word($sformatf("store %0d data", store_count),
                               exp_data_q.pop_front(), pwdata);
                    store_count++;
                end
            end
        end
    end

    // ============================================================
    // main sequence
    // ============================================================

    initial begin : main_seq
        int cycles;
        int ref_steps;
        store_count = 0;
        first_seen  = 1'b0;
        build_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] = image[i];
        end
        ref_steps = run_reference();
        if (ref_steps < 0) begin
            report_problem("the reference model never reached the halt instruction");
        end
        exp_count = exp_addr_q.size();

        cycles = 0;
        do begin
            @(negedge sys_clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                report_problem("reset was never released");
            end
        end while (sys_rst !== 1'b0);

        check_flag("psel after reset", 1'b0, psel);
        check_flag("penable after reset", 1'b0, penable);
        check_flag("pwrite after reset", 1'b0, pwrite);
        check_flag("halted after reset", 1'b0, halted);

        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge sys_clk);
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                report_problem("the core did not halt in time");
            end
        end

        // core must stay quiet once halted
        for (int i = 0; i < 50; i++) begin
            @(negedge sys_clk);
            check_flag("psel while halted", 1'b0, psel);
        end
        check_word("store count", word_t'(exp_count), word_t'(store_count));

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_reg_file.sv
logic/rv_execute.sv
logic/rv_apb_master.sv
logic/rv_ctl_unit.sv
logic/rv_core_top.sv
tests/tb_clk_gen.sv
tests/tb_apb_mem.sv
tests/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_decoder.sv
  - logic/rv_reg_file.sv
  - logic/rv_execute.sv
  - logic/rv_apb_master.sv
  - logic/rv_ctl_unit.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_apb_mem.sv
      - tests/tb_rv_core.sv
